// ==== sources.f ====
src/arp_pkg.sv
src/crc32_d8.sv
src/arp_rx.sv
src/arp_tx.sv
src/arp.sv
tb/arp_tb.sv

// ==== Makefile ====
# Verilator build and run of the ARP responder testbench

TOP       ?= arp_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/arp_tb.sv ====
`timescale 1ns/1ps

module arp_tb;

  logic        gmii_clk = 1'b0;
  logic        arst_n;
  logic        gmii_rx_dv;
  logic [7:0]  gmii_rxd;
  logic        gmii_tx_en;
  logic [7:0]  gmii_txd;
  logic        arp_tx_sel;
  logic        arp_tx_done;
  logic        arp_tx_req;
  logic        arp_working;
  logic [47:0] dec_mac;
  logic [31:0] dec_ip;
  logic        refresh;

  logic [7:0]  frame_buf [0:71];  // Preamble, 60 frame bytes, FCS
  logic [7:0]  tx_bytes [0:79];
  int          tx_len = 0;
  int          tx_frames = 0;
  logic        tx_prev = 1'b0;
  int          rx_idx;            // Index after the SFD of the byte on gmii_rxd
  logic        expect_accept;
  logic        want_req;
  logic [31:0] lfsr_state = 32'h772b;
  logic [47:0] last_mac = '0;
  logic [31:0] last_ip = '0;
  logic [47:0] req_mac;
  logic [31:0] req_ip;
  int          grant_delay;
  int          wait_cnt;
  int          mismatches = 0;
  int          timeouts = 0;

  arp uut (.*);

  always #20 gmii_clk = ~gmii_clk;

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [47:0] rand_bits(input int n);
    logic [47:0] r;
    logic        lsb;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      r = {r[46:0], lsb};
    end
    return r;
  endfunction

  // Bitwise reflected CRC-32 over the 60 frame bytes
  function automatic logic [31:0] frame_crc();
    logic [31:0] c;
    c = 32'hffff_ffff;
    for (int i = 0; i < arp_pkg::min_frame_len; i++) begin
      c = c ^ {24'h0, frame_buf[arp_pkg::preamble_len + i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic build_frame(input logic [47:0] dst, input logic [47:0] src,
                             input logic [15:0] etype, input logic [15:0] op,
                             input logic [47:0] sha, input logic [31:0] spa,
                             input logic [47:0] tha, input logic [31:0] tpa);
    logic [335:0] hdr;
    logic [31:0]  fcs;
    hdr = {dst, src, etype, arp_pkg::arp_htype_eth, arp_pkg::arp_ptype_ipv4,
           arp_pkg::arp_hlen, arp_pkg::arp_plen, op, sha, spa, tha, tpa};
    for (int i = 0; i < 7; i++) begin
      frame_buf[i] = arp_pkg::preamble_byte;
    end
    frame_buf[7] = arp_pkg::sfd_byte;
    for (int i = 0; i < 60; i++) begin
      frame_buf[8 + i] = (i < 42) ? hdr[8 * (41 - i) +: 8] : 8'h00;  // Zero padding
    end
    fcs = frame_crc();
    for (int i = 0; i < 4; i++) begin
      frame_buf[68 + i] = fcs[8 * i +: 8];  // Low byte first
    end
  endtask

  task automatic send_frame();
    for (int i = 0; i < 72; i++) begin
      @(negedge gmii_clk);
      gmii_rx_dv = 1'b1;
      gmii_rxd = frame_buf[i];
      rx_idx = i - arp_pkg::preamble_len;
    end
    @(negedge gmii_clk);
    gmii_rx_dv = 1'b0;
    gmii_rxd = 8'h00;
    rx_idx = -100;
    @(negedge gmii_clk);  // Short interframe gap
  endtask

  task automatic run_frame(input logic [47:0] dst, input logic [15:0] etype,
                           input logic [15:0] op, input logic [47:0] sha,
                           input logic [31:0] spa, input logic [31:0] tpa,
                           input logic accept);
    expect_accept = accept;
    want_req = (op == arp_pkg::arp_op_request);
    build_frame(dst, sha, etype, op, sha, spa, 48'h0, tpa);
    send_frame();
    if (accept) begin
      last_mac = sha;
      last_ip = spa;
    end
    assert (dec_mac == last_mac && dec_ip == last_ip) else
      report_mismatch($sformatf("dec_mac %h dec_ip %h, expected %h %h",
                                dec_mac, dec_ip, last_mac, last_ip));
    assert (arp_tx_req == (accept && want_req)) else
      report_mismatch($sformatf("arp_tx_req is %b after the frame", arp_tx_req));
  endtask

  // Transmit capture of one byte per cycle in the latest gmii_tx_en run
  always @(negedge gmii_clk) begin
    if (gmii_tx_en) begin
      if (!tx_prev) begin
        tx_len = 0;
        tx_frames++;
      end
      if (tx_len < 80) begin
        tx_bytes[tx_len] = gmii_txd;
      end
      tx_len++;
    end
    tx_prev = gmii_tx_en;
  end

  refresh_on_match: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    rx_idx == arp_pkg::arp_end_offset && expect_accept |=> refresh)
    else report_mismatch("no refresh after a matching frame");

  refresh_only_on_match: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    refresh |-> $past(rx_idx == arp_pkg::arp_end_offset && expect_accept))
    else report_mismatch("refresh outside the last target IP byte of a matching frame");

  req_after_request: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    refresh && want_req |=> arp_tx_req)
    else report_mismatch("arp_tx_req did not follow a request");

  no_req_after_reply: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    refresh && !want_req |=> !arp_tx_req)
    else report_mismatch("arp_tx_req raised for a reply");

  req_held_to_grant: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    arp_tx_req && !arp_tx_sel |=> arp_tx_req)
    else report_mismatch("arp_tx_req dropped before the grant");

  tx_after_grant: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    arp_tx_req && arp_tx_sel |=> gmii_tx_en)
    else report_mismatch("gmii_tx_en did not rise after the grant");

  working_covers_tx: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    (arp_tx_req && arp_tx_sel) || gmii_tx_en || arp_tx_done |-> arp_working)
    else report_mismatch("arp_working low between the grant and arp_tx_done");

  working_ends_after_done: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    arp_tx_done |=> arp_working == (arp_tx_req && arp_tx_sel))
    else report_mismatch("arp_working still high after arp_tx_done");

  done_after_last: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    $fell(gmii_tx_en) |-> arp_tx_done)
    else report_mismatch("arp_tx_done missing after the last byte");

  done_at_end_only: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    arp_tx_done |-> $past(gmii_tx_en) && !gmii_tx_en)
    else report_mismatch("arp_tx_done outside the end of the frame");

  done_single: assert property (@(posedge gmii_clk) disable iff (!arst_n)
    arp_tx_done |=> !arp_tx_done)
    else report_mismatch("arp_tx_done longer than one cycle");

  initial begin
    arst_n = 1'b0;
    gmii_rx_dv = 1'b0;
    gmii_rxd = 8'h00;
    arp_tx_sel = 1'b0;
    rx_idx = -100;
    expect_accept = 1'b0;
    want_req = 1'b0;
    repeat (3) @(posedge gmii_clk);
    @(negedge gmii_clk);
    arst_n = 1'b1;
    assert (!gmii_tx_en && !arp_tx_req && !arp_tx_done && !arp_working && !refresh &&
            dec_mac == '0 && dec_ip == '0) else
      report_mismatch("outputs not idle after reset");

    // Request from a random sender
    req_mac = rand_bits(48);
    req_ip = 32'(rand_bits(32));
    run_frame(48'hffff_ffff_ffff, arp_pkg::eth_type_arp, arp_pkg::arp_op_request,
              req_mac, req_ip, arp_pkg::board_ip, 1'b1);

    // Arbiter holds off and then grants
    grant_delay = int'(rand_bits(4)) + 2;
    repeat (grant_delay) @(negedge gmii_clk);
    arp_tx_sel = 1'b1;
    wait_cnt = 0;
    while (!gmii_tx_en && wait_cnt < 10) begin
      @(negedge gmii_clk);
      wait_cnt++;
    end
    if (!gmii_tx_en) begin
      timeouts++;
      $display("timeout: gmii_tx_en did not rise within 10 cycles of the grant");
    end
    arp_tx_sel = 1'b0;
    wait_cnt = 0;
    while (!arp_tx_done && wait_cnt < 100) begin
      @(negedge gmii_clk);
      wait_cnt++;
    end
    if (!arp_tx_done) begin
      timeouts++;
      $display("timeout: arp_tx_done did not pulse within 100 cycles");
    end

    // Expected reply with the testbench FCS
    build_frame(req_mac, arp_pkg::board_mac, arp_pkg::eth_type_arp, arp_pkg::arp_op_reply,
                arp_pkg::board_mac, arp_pkg::board_ip, req_mac, req_ip);
    assert (tx_frames == 1 && tx_len == 72) else
      report_mismatch($sformatf("%0d frames, last run %0d cycles", tx_frames, tx_len));
    for (int i = 0; i < 72; i++) begin
      assert (tx_bytes[i] === frame_buf[i]) else
        report_mismatch($sformatf("tx byte %0d is %h, expected %h", i, tx_bytes[i],
                                  frame_buf[i]));
    end
    wait_cnt = 0;
    while (arp_working && wait_cnt < 10) begin
      @(negedge gmii_clk);
      wait_cnt++;
    end
    if (arp_working) begin
      timeouts++;
      $display("timeout: arp_working stayed high after the reply");
    end

    // Reply to the board and then frames that must be ignored
    run_frame(arp_pkg::board_mac, arp_pkg::eth_type_arp, arp_pkg::arp_op_reply,
              rand_bits(48), 32'(rand_bits(32)), arp_pkg::board_ip, 1'b1);
    run_frame(48'hffff_ffff_ffff, arp_pkg::eth_type_arp, arp_pkg::arp_op_request,
              rand_bits(48), 32'(rand_bits(32)), arp_pkg::board_ip ^ 32'h1, 1'b0);
    run_frame(48'hffff_ffff_ffff, 16'h0800, arp_pkg::arp_op_request,
              rand_bits(48), 32'(rand_bits(32)), arp_pkg::board_ip, 1'b0);
    run_frame(48'h02_00_00_00_00_01, arp_pkg::eth_type_arp, arp_pkg::arp_op_request,
              rand_bits(48), 32'(rand_bits(32)), arp_pkg::board_ip, 1'b0);

    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src/arp.sv ====
`timescale 1ns/1ps

module arp (
  input  logic        gmii_clk,
  input  logic        arst_n,
  input  logic        gmii_rx_dv,
  input  logic [7:0]  gmii_rxd,
  output logic        gmii_tx_en,
  output logic [7:0]  gmii_txd,
  input  logic        arp_tx_sel,
  output logic        arp_tx_done,
  output logic        arp_tx_req,
  output logic        arp_working,
  output logic [47:0] dec_mac,     // Sender MAC of the last accepted frame
  output logic [31:0] dec_ip,      // Sender IP of the last accepted frame
  output logic        refresh
);

  arp_pkg::arp_peer_t peer;
  logic               peer_valid;
  logic               crc_en;
  logic               crc_clr;
  logic [31:0]        crc_data;

  arp_rx arp_rx_inst (
    .gmii_clk   (gmii_clk),
    .arst_n     (arst_n),
    .gmii_rx_dv (gmii_rx_dv),
    .gmii_rxd   (gmii_rxd),
    .peer       (peer),
    .peer_valid (peer_valid)
  );

  arp_tx arp_tx_inst (
    .gmii_clk    (gmii_clk),
    .arst_n      (arst_n),
    .peer        (peer),
    .peer_valid  (peer_valid),
    .arp_tx_sel  (arp_tx_sel),
    .arp_tx_req  (arp_tx_req),
    .arp_tx_done (arp_tx_done),
    .arp_working (arp_working),
    .gmii_tx_en  (gmii_tx_en),
    .gmii_txd    (gmii_txd),
    .crc_en      (crc_en),
    .crc_clr     (crc_clr),
    .crc_data    (crc_data)
  );

  crc32_d8 crc32_d8_inst (
    .gmii_clk (gmii_clk),
    .arst_n   (arst_n),
    .data     (gmii_txd),   // CRC runs over the transmitted bytes
    .crc_en   (crc_en),
    .crc_clr  (crc_clr),
    .crc_data (crc_data)
  );

  assign dec_mac = peer.mac;
  assign dec_ip  = peer.ip;
  assign refresh = peer_valid;

endmodule

// ==== src/arp_tx.sv ====
`timescale 1ns/1ps

module arp_tx (
  input  logic               gmii_clk,
  input  logic               arst_n,
  input  arp_pkg::arp_peer_t peer,
  input  logic               peer_valid,
  input  logic               arp_tx_sel,    // Grant from the arbiter
  output logic               arp_tx_req,
  output logic               arp_tx_done,
  output logic               arp_working,
  output logic               gmii_tx_en,
  output logic [7:0]         gmii_txd,
  output logic               crc_en,
  output logic               crc_clr,
  input  logic [31:0]        crc_data
);

  arp_pkg::arp_peer_t pend_q;  // is_request doubles as the pending flag
  logic [47:0] dst_mac;         // Requester being answered
  logic [31:0] dst_ip;
  logic        busy;
  logic        grant;
  logic [6:0]  idx;             // Index of the byte on gmii_txd
  logic [6:0]  next_idx;
  logic [6:0]  hdr_idx;
  logic [7:0]  txd_q;
  logic [7:0]  next_byte;
  logic        fcs_phase;
  logic [1:0]  fcs_sel;
  logic [(arp_pkg::arp_end_offset+1)*8-1:0] frame_hdr;

  assign grant       = arp_tx_req & arp_tx_sel;
  assign arp_tx_req  = pend_q.is_request & ~busy;
  assign arp_working = busy | grant;

  // Newest request wins the single slot
  always_ff @(posedge gmii_clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q <= '0;
    end else begin
      if (grant) begin
        pend_q.is_request <= 1'b0;
      end
      if (peer_valid && peer.is_request) begin
        pend_q <= peer;
      end
    end
  end

  always_ff @(posedge gmii_clk) begin
    if (grant) begin
      dst_mac <= pend_q.mac;
      dst_ip  <= pend_q.ip;
    end
  end

  // Ethernet header and ARP reply body, byte 0 in the top bits
  assign frame_hdr = {dst_mac, arp_pkg::board_mac, arp_pkg::eth_type_arp,
                      arp_pkg::arp_htype_eth, arp_pkg::arp_ptype_ipv4,
                      arp_pkg::arp_hlen, arp_pkg::arp_plen, arp_pkg::arp_op_reply,
                      arp_pkg::board_mac, arp_pkg::board_ip, dst_mac, dst_ip};

  assign next_idx = idx + 7'd1;

  always_comb begin
    hdr_idx   = next_idx - 7'(arp_pkg::preamble_len);
    next_byte = 8'h00;  // Padding and idle
    if (next_idx < 7'(arp_pkg::preamble_len - 1)) begin
      next_byte = arp_pkg::preamble_byte;
    end else if (next_idx == 7'(arp_pkg::preamble_len - 1)) begin
      next_byte = arp_pkg::sfd_byte;
    end else if (hdr_idx <= 7'(arp_pkg::arp_end_offset)) begin
      next_byte = frame_hdr[8*(arp_pkg::arp_end_offset - hdr_idx) +: 8];
    end
  end

  always_ff @(posedge gmii_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy        <= 1'b0;
      gmii_tx_en  <= 1'b0;
      arp_tx_done <= 1'b0;
      idx         <= '0;
      txd_q       <= '0;
    end else begin
      arp_tx_done <= 1'b0;
      if (grant) begin
        busy       <= 1'b1;
        gmii_tx_en <= 1'b1;
        idx        <= '0;
        txd_q      <= arp_pkg::preamble_byte;
      end else if (gmii_tx_en) begin
        txd_q <= next_byte;
        if (idx == 7'(arp_pkg::preamble_len + arp_pkg::min_frame_len +
                      arp_pkg::fcs_len - 1)) begin
          gmii_tx_en  <= 1'b0;
          arp_tx_done <= 1'b1;
        end else begin
          idx <= next_idx;
        end
      end else if (arp_tx_done) begin
        busy <= 1'b0;  // Free after the done cycle
      end
    end
  end

  // FCS comes straight from the CRC engine, which settles after the last frame byte
  assign fcs_phase = gmii_tx_en &&
                     idx >= 7'(arp_pkg::preamble_len + arp_pkg::min_frame_len);
  assign fcs_sel   = 2'(idx - 7'(arp_pkg::preamble_len + arp_pkg::min_frame_len));
  assign gmii_txd  = fcs_phase ? crc_data[8*fcs_sel +: 8] : txd_q;

  assign crc_clr = gmii_tx_en && idx < 7'(arp_pkg::preamble_len);
  assign crc_en  = gmii_tx_en && !crc_clr && !fcs_phase;

  tx_within_working: assert property (
    @(posedge gmii_clk) disable iff (!arst_n) gmii_tx_en |-> arp_working
  ) else $error("arp_tx: gmii_tx_en outside arp_working");

  req_held_to_grant: assert property (
    @(posedge gmii_clk) disable iff (!arst_n) $fell(arp_tx_req) |-> $past(arp_tx_sel)
  ) else $error("arp_tx: arp_tx_req dropped without a grant");

endmodule

// ==== src/arp_rx.sv ====
`timescale 1ns/1ps

module arp_rx (
  input  logic               gmii_clk,
  input  logic               arst_n,
  input  logic               gmii_rx_dv,
  input  logic [7:0]         gmii_rxd,
  output arp_pkg::arp_peer_t peer,        // Last accepted sender
  output logic               peer_valid   // One cycle per accepted frame
);

  logic        pre_seen;        // Previous byte was preamble
  logic        in_frame;
  logic [5:0]  cnt;             // Byte index after the SFD
  logic        field_ok;
  logic        bcast_ok;
  logic        board_ok;
  logic [15:0] opcode;
  logic [47:0] sender_mac;
  logic [31:0] sender_ip;
  logic [7:0]  exp_byte;
  logic        chk;
  logic        byte_mismatch;
  logic        accept;

  // Expected value of the byte at cnt
  always_comb begin
    exp_byte = 8'h00;
    case (cnt)
      6'd0:    exp_byte = arp_pkg::board_mac[47:40];
      6'd1:    exp_byte = arp_pkg::board_mac[39:32];
      6'd2:    exp_byte = arp_pkg::board_mac[31:24];
      6'd3:    exp_byte = arp_pkg::board_mac[23:16];
      6'd4:    exp_byte = arp_pkg::board_mac[15:8];
      6'd5:    exp_byte = arp_pkg::board_mac[7:0];
      6'd12:   exp_byte = arp_pkg::eth_type_arp[15:8];
      6'd13:   exp_byte = arp_pkg::eth_type_arp[7:0];
      6'd14:   exp_byte = arp_pkg::arp_htype_eth[15:8];
      6'd15:   exp_byte = arp_pkg::arp_htype_eth[7:0];
      6'd16:   exp_byte = arp_pkg::arp_ptype_ipv4[15:8];
      6'd17:   exp_byte = arp_pkg::arp_ptype_ipv4[7:0];
      6'd18:   exp_byte = arp_pkg::arp_hlen;
      6'd19:   exp_byte = arp_pkg::arp_plen;
      6'd38:   exp_byte = arp_pkg::board_ip[31:24];
      6'd39:   exp_byte = arp_pkg::board_ip[23:16];
      6'd40:   exp_byte = arp_pkg::board_ip[15:8];
      6'd41:   exp_byte = arp_pkg::board_ip[7:0];
      default: exp_byte = 8'h00;
    endcase
  end

  // EtherType through PLEN, and the target IP
  assign chk = (cnt >= 6'd12 && cnt <= 6'd19) || cnt >= 6'd38;
  assign byte_mismatch = chk && (gmii_rxd != exp_byte);

  assign accept = field_ok && !byte_mismatch && (bcast_ok || board_ok) &&
                  (opcode == arp_pkg::arp_op_request || opcode == arp_pkg::arp_op_reply);

  always_ff @(posedge gmii_clk or negedge arst_n) begin
    if (!arst_n) begin
      pre_seen   <= 1'b0;
      in_frame   <= 1'b0;
      cnt        <= '0;
      field_ok   <= 1'b0;
      bcast_ok   <= 1'b0;
      board_ok   <= 1'b0;
      peer       <= '0;
      peer_valid <= 1'b0;
    end else begin
      peer_valid <= 1'b0;
      if (!gmii_rx_dv) begin
        pre_seen <= 1'b0;
        in_frame <= 1'b0;
      end else if (!in_frame) begin
        pre_seen <= (gmii_rxd == arp_pkg::preamble_byte);
        if (pre_seen && gmii_rxd == arp_pkg::sfd_byte) begin
          in_frame <= 1'b1;
          cnt      <= '0;
          field_ok <= 1'b1;
          bcast_ok <= 1'b1;
          board_ok <= 1'b1;
        end
      end else if (cnt <= 6'(arp_pkg::arp_end_offset)) begin
        cnt <= cnt + 6'd1;  // Stops one past the target IP
        if (byte_mismatch) begin
          field_ok <= 1'b0;
        end
        if (cnt < 6'd6) begin
          if (gmii_rxd != 8'hff) begin
            bcast_ok <= 1'b0;
          end
          if (gmii_rxd != exp_byte) begin
            board_ok <= 1'b0;
          end
        end
        if (cnt == 6'(arp_pkg::arp_end_offset) && accept) begin
          peer.mac        <= sender_mac;
          peer.ip         <= sender_ip;
          peer.is_request <= (opcode == arp_pkg::arp_op_request);
          peer_valid      <= 1'b1;
        end
      end
    end
  end

  // Shadow copies of the sender fields
  always_ff @(posedge gmii_clk) begin
    if (gmii_rx_dv && in_frame) begin
      if (cnt == 6'd20 || cnt == 6'd21) begin
        opcode <= {opcode[7:0], gmii_rxd};
      end
      if (cnt >= 6'd22 && cnt <= 6'd27) begin
        sender_mac <= {sender_mac[39:0], gmii_rxd};
      end
      if (cnt >= 6'd28 && cnt <= 6'd31) begin
        sender_ip <= {sender_ip[23:0], gmii_rxd};
      end
    end
  end

  single_refresh: assert property (
    @(posedge gmii_clk) disable iff (!arst_n) peer_valid |=> !peer_valid
  ) else $error("arp_rx: peer_valid held for two cycles");

endmodule

// ==== src/crc32_d8.sv ====
`timescale 1ns/1ps

module crc32_d8 (
  input  logic        gmii_clk,
  input  logic        arst_n,
  input  logic [7:0]  data,      // Byte being sent
  input  logic        crc_en,    // Fold data into the remainder
  input  logic        crc_clr,   // Restart from the initial value
  output logic [31:0] crc_data   // FCS, low byte goes out first
);

  logic [31:0] crc_q;
  logic [31:0] crc_d;

  // One byte, LSB first, through the reflected polynomial
  always_comb begin
    crc_d = crc_q;
    for (int i = 0; i < 8; i++) begin
      if (crc_d[0] ^ data[i]) begin
        crc_d = (crc_d >> 1) ^ arp_pkg::crc_poly;
      end else begin
        crc_d = crc_d >> 1;
      end
    end
  end

  always_ff @(posedge gmii_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_q <= arp_pkg::crc_init;
    end else if (crc_clr) begin
      crc_q <= arp_pkg::crc_init;
    end else if (crc_en) begin
      crc_q <= crc_d;
    end
  end

  // Reflected register is already in wire bit order
  assign crc_data = crc_q ^ arp_pkg::crc_residue_xor;

  // The generator clears only during the preamble and folds only frame bytes
  clr_en_exclusive: assert property (
    @(posedge gmii_clk) disable iff (!arst_n) !(crc_en && crc_clr)
  ) else $error("crc32_d8: clear and enable high together");

endmodule

// ==== src/arp_pkg.sv ====
package arp_pkg;

  // Board identity
  localparam logic [47:0] board_mac = 48'h12_34_56_78_9a_bc;
  localparam logic [31:0] board_ip  = {8'd192, 8'd168, 8'd1, 8'd10};

  // Ethernet and ARP field values
  localparam logic [15:0] eth_type_arp   = 16'h0806;
  localparam logic [15:0] arp_htype_eth  = 16'h0001;
  localparam logic [15:0] arp_ptype_ipv4 = 16'h0800;
  localparam logic [7:0]  arp_hlen       = 8'd6;   // MAC length in bytes
  localparam logic [7:0]  arp_plen       = 8'd4;   // IPv4 length in bytes
  localparam logic [15:0] arp_op_request = 16'h0001;
  localparam logic [15:0] arp_op_reply   = 16'h0002;

  // GMII framing
  localparam logic [7:0] preamble_byte = 8'h55;
  localparam logic [7:0] sfd_byte      = 8'hd5;
  localparam int         preamble_len  = 8;       // Seven preamble bytes plus SFD

  // Frame lengths, counted from the first byte after the SFD
  localparam int min_frame_len  = 60;  // Without FCS
  localparam int fcs_len        = 4;
  localparam int arp_end_offset = 41;  // Last byte of the target IP

  // Ethernet CRC-32, reflected form
  localparam logic [31:0] crc_init        = 32'hffff_ffff;
  localparam logic [31:0] crc_poly        = 32'hedb8_8320;
  localparam logic [31:0] crc_residue_xor = 32'hffff_ffff;

  // Peer learned from an accepted ARP frame
  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic        is_request;
  } arp_peer_t;

endpackage
